// File: rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

  localparam int xlen = 64;

  // major opcodes, instr[6:0].
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_system = 7'b1110011
  } rv_opcode_e;

  typedef enum logic [2:0] {
    cls_alu,
    cls_branch,
    cls_jump,
    cls_load,
    cls_store,
    cls_csr,
    cls_trap,
    cls_nop
  } exec_class_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_xor,
    alu_or,
    alu_and,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_seq   // beq and bne only.
  } alu_op_e;

  typedef enum logic [2:0] {
    csr_rw,
    csr_rs,
    csr_rc,
    csr_ecall,
    csr_mret,
    csr_ebreak
  } csr_op_e;

  typedef enum logic [11:0] {
    csr_mstatus = 12'h300,
    csr_mtvec   = 12'h305,
    csr_mepc    = 12'h341,
    csr_mcause  = 12'h342
  } csr_addr_e;

  localparam logic [xlen-1:0] cause_ecall_m = 64'd11;

endpackage

`default_nettype wire

// File: rv_stage_if.sv
`timescale 1ns/100ps
`default_nettype none

interface dec_if;
  import rv_exec_pkg::*;
  logic        valid, ready;
  exec_class_e cls;
  alu_op_e     alu_op;
  csr_op_e     csr_op;
  logic [2:0]  funct3;
  logic [4:0]  rd;
  logic        rd_we;
  logic [xlen-1:0] src1, src2, imm, pc;
  modport source (output valid, cls, alu_op, csr_op, funct3, rd, rd_we, src1, src2, imm, pc,
                  input ready);
  modport sink (input valid, cls, alu_op, csr_op, funct3, rd, rd_we, src1, src2, imm, pc,
                output ready);
endinterface

interface res_if;
  import rv_exec_pkg::*;
  logic            valid, ready;
  logic [4:0]      rd;
  logic            rd_we, ebreak;
  logic [xlen-1:0] rd_data, npc;
  modport source (output valid, rd, rd_we, rd_data, npc, ebreak, input ready);
  modport sink (input valid, rd, rd_we, rd_data, npc, ebreak, output ready);
endinterface

`default_nettype wire

// File: rv_alu.sv
`timescale 1ns/100ps
`default_nettype none

module rv_alu (
  input  wire [rv_exec_pkg::xlen-1:0] a_i,
  input  wire [rv_exec_pkg::xlen-1:0] b_i,
  input  rv_exec_pkg::alu_op_e        op_i,
  output logic [rv_exec_pkg::xlen-1:0] res_o
);
  import rv_exec_pkg::*;

  logic [5:0] shamt;

  assign shamt = b_i[5:0];

  always_comb begin
    case (op_i)
      alu_add:  res_o = a_i + b_i;
      alu_sub:  res_o = a_i - b_i;
      alu_xor:  res_o = a_i ^ b_i;
      alu_or:   res_o = a_i | b_i;
      alu_and:  res_o = a_i & b_i;
      alu_sll:  res_o = a_i << shamt;
      alu_srl:  res_o = a_i >> shamt;
      alu_sra:  res_o = $signed(a_i) >>> shamt;
      alu_slt:  res_o = xlen'($signed(a_i) < $signed(b_i));
      alu_sltu: res_o = xlen'(a_i < b_i);
      alu_seq:  res_o = xlen'(a_i == b_i);
      default:  res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: rv_csr_file.sv
`timescale 1ns/100ps
`default_nettype none

module rv_csr_file (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         we_i,
  input  rv_exec_pkg::csr_addr_e      addr_i,
  input  wire [rv_exec_pkg::xlen-1:0] wdata_i,
  input  wire                         trap_i,
  input  wire                         mret_i,
  input  wire [rv_exec_pkg::xlen-1:0] trap_pc_i,
  output logic [rv_exec_pkg::xlen-1:0] rdata_o,
  output logic [rv_exec_pkg::xlen-1:0] mepc_o,
  output logic [rv_exec_pkg::xlen-1:0] mtvec_o
);
  import rv_exec_pkg::*;

  logic [xlen-1:0] mstatus, mtvec, mepc, mcause;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (trap_i) begin
      mepc   <= trap_pc_i;
      mcause <= cause_ecall_m;
    end else if (mret_i) begin
      mstatus[3] <= mstatus[7];  // mie <= mpie.
      mstatus[7] <= 1'b1;
    end else if (we_i) begin
      case (addr_i)
        csr_mstatus: mstatus <= wdata_i;
        csr_mtvec:   mtvec   <= wdata_i;
        csr_mepc:    mepc    <= wdata_i;
        csr_mcause:  mcause  <= wdata_i;
        default: ;   // unknown address, dropped.
      endcase
    end
  end

  always_comb begin
    case (addr_i)
      csr_mstatus: rdata_o = mstatus;
      csr_mtvec:   rdata_o = mtvec;
      csr_mepc:    rdata_o = mepc;
      csr_mcause:  rdata_o = mcause;
      default:     rdata_o = '0;
    endcase
  end

  assign mepc_o  = mepc;
  assign mtvec_o = mtvec;

  assert property (@(posedge clk) disable iff (rst) !(trap_i && mret_i));

endmodule

`default_nettype wire

// File: rv_decode.sv
`timescale 1ns/100ps
`default_nettype none

module rv_decode (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        in_valid_i,
  output logic                       in_ready_o,
  input  wire [31:0]                 instr_i,
  input  wire [rv_exec_pkg::xlen-1:0] pc_i,
  input  wire [rv_exec_pkg::xlen-1:0] rs1_data_i,
  input  wire [rv_exec_pkg::xlen-1:0] rs2_data_i,
  dec_if.source                      dec
);
  import rv_exec_pkg::*;

  rv_opcode_e      opc;
  logic [2:0]      f3;
  logic [6:0]      f7;
  exec_class_e     cls_c;
  alu_op_e         alu_c;
  csr_op_e         csr_c;
  logic [xlen-1:0] imm_c, src1_c, src2_c;

  assign opc = rv_opcode_e'(instr_i[6:0]);
  assign f3  = instr_i[14:12];
  assign f7  = instr_i[31:25];

  always_comb begin
    cls_c  = cls_nop;
    alu_c  = alu_add;
    csr_c  = csr_rw;
    imm_c  = {{52{instr_i[31]}}, instr_i[31:20]};  // I-type by default.
    src1_c = rs1_data_i;
    src2_c = rs2_data_i;
    case (f3)
      3'b000: alu_c = (opc == opc_op && f7[5]) ? alu_sub : alu_add;
      3'b001: alu_c = alu_sll;
      3'b010: alu_c = alu_slt;
      3'b011: alu_c = alu_sltu;
      3'b100: alu_c = alu_xor;
      3'b101: alu_c = f7[5] ? alu_sra : alu_srl;
      3'b110: alu_c = alu_or;
      default: alu_c = alu_and;
    endcase
    case (opc)
      opc_op: begin
        if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))) cls_c = cls_alu;
      end
      opc_op_imm: begin
        cls_c  = cls_alu;
        src2_c = imm_c;
      end
      opc_lui: begin
        cls_c  = cls_alu;
        alu_c  = alu_add;
        imm_c  = {{32{instr_i[31]}}, instr_i[31:12], 12'b0};
        src1_c = '0;
        src2_c = imm_c;
      end
      opc_branch: begin
        imm_c = {{52{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
        if (f3[2:1] != 2'b01) cls_c = cls_branch;
        alu_c = (f3[2:1] == 2'b00) ? alu_seq : (f3[1] ? alu_sltu : alu_slt);
      end
      opc_jal: begin
        cls_c  = cls_jump;
        imm_c  = {{44{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
        src1_c = pc_i;   // jump target is src1 + imm for both jumps.
      end
      opc_jalr: if (f3 == 3'b000) cls_c = cls_jump;
      opc_load: if (f3 == 3'b011) cls_c = cls_load;
      opc_store: begin
        imm_c = {{52{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
        if (f3 == 3'b011) cls_c = cls_store;
      end
      opc_system: begin
        case (f3)
          3'b000: begin
            cls_c = cls_trap;
            case (instr_i[31:20])
              12'h000: csr_c = csr_ecall;
              12'h001: csr_c = csr_ebreak;
              12'h302: csr_c = csr_mret;
              default: cls_c = cls_nop;
            endcase
          end
          3'b001: begin cls_c = cls_csr; csr_c = csr_rw; end
          3'b010: begin cls_c = cls_csr; csr_c = csr_rs; end
          3'b011: begin cls_c = cls_csr; csr_c = csr_rc; end
          default: cls_c = cls_nop;  // immediate forms not handled.
        endcase
      end
      default: cls_c = cls_nop;
    endcase
  end

  assign in_ready_o = !dec.valid || dec.ready;

  always_ff @(posedge clk) begin
    if (rst) dec.valid <= 1'b0;
    else if (in_ready_o) dec.valid <= in_valid_i;
  end

  always_ff @(posedge clk) begin
    if (in_ready_o && in_valid_i) begin
      dec.cls    <= cls_c;
      dec.alu_op <= alu_c;
      dec.csr_op <= csr_c;
      dec.funct3 <= f3;
      dec.rd     <= instr_i[11:7];
      dec.rd_we  <= cls_c inside {cls_alu, cls_jump, cls_load, cls_csr};
      dec.src1   <= src1_c;
      dec.src2   <= src2_c;
      dec.imm    <= imm_c;
      dec.pc     <= pc_i;
    end
  end

  // a stalled item must not change under execute.
  assert property (@(posedge clk) disable iff (rst)
    dec.valid && !dec.ready |=> dec.valid && $stable(dec.pc) && $stable(dec.src1));

endmodule

`default_nettype wire

// File: rv_execute.sv
`timescale 1ns/100ps
`default_nettype none

module rv_execute (
  input  wire                         clk,
  input  wire                         rst,
  dec_if.sink                         dec,
  res_if.source                       res,
  output logic                        mem_req_o,
  output logic                        mem_we_o,
  output logic [rv_exec_pkg::xlen-1:0] mem_addr_o,
  output logic [rv_exec_pkg::xlen-1:0] mem_wdata_o,
  input  wire [rv_exec_pkg::xlen-1:0] mem_rdata_i,
  input  wire                         mem_rvalid_i,
  input  wire                         mem_wready_i
);
  import rv_exec_pkg::*;

  typedef enum logic [1:0] {st_idle, st_mem_wait, st_hold} state_e;

  state_e          state;
  exec_class_e     cls_q;
  alu_op_e         alu_op_q;
  csr_op_e         csr_op_q;
  logic [2:0]      f3_q;
  logic [4:0]      rd_q;
  logic            rd_we_q;
  logic [xlen-1:0] src1_q, src2_q, imm_q, pc_q;
  logic [xlen-1:0] alu_res, pc4, jump_sum, csr_old, csr_new, mepc, mtvec;
  logic [xlen-1:0] rd_data_c, npc_c;
  logic            mem_done, load_res, taken;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign dec.ready = (state == st_idle);
  assign mem_done  = mem_we_o ? mem_wready_i : mem_rvalid_i;
  assign load_res  = (state == st_hold && !res.valid) || (state == st_mem_wait && mem_done);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      res.valid <= 1'b0;
      mem_req_o <= 1'b0;
    end else begin
      case (state)
        st_idle: if (dec.valid) begin
          state     <= (dec.cls inside {cls_load, cls_store}) ? st_mem_wait : st_hold;
          mem_req_o <= dec.cls inside {cls_load, cls_store};
        end
        st_mem_wait: if (mem_done) begin
          mem_req_o <= 1'b0;
          res.valid <= 1'b1;
          state     <= st_hold;
        end
        st_hold: begin
          if (!res.valid) res.valid <= 1'b1;  // result registered this edge.
          else if (res.ready) begin
            res.valid <= 1'b0;
            state     <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (dec.valid && dec.ready) begin
      cls_q    <= dec.cls;
      alu_op_q <= dec.alu_op;
      csr_op_q <= dec.csr_op;
      f3_q     <= dec.funct3;
      rd_q     <= dec.rd;
      rd_we_q  <= dec.rd_we;
      src1_q   <= dec.src1;
      src2_q   <= dec.src2;
      imm_q    <= dec.imm;
      pc_q     <= dec.pc;
    end
    if (load_res) begin
      res.rd      <= rd_q;
      res.rd_we   <= rd_we_q;
      res.rd_data <= rd_data_c;
      res.npc     <= npc_c;
      res.ebreak  <= (cls_q == cls_trap) && (csr_op_q == csr_ebreak);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  rv_alu rv_alu_inst (
    .a_i   (src1_q),
    .b_i   (src2_q),
    .op_i  (alu_op_q),
    .res_o (alu_res)
  );

  rv_csr_file rv_csr_file_inst (
    .clk       (clk),
    .rst       (rst),
    .we_i      (load_res && cls_q == cls_csr),
    .addr_i    (csr_addr_e'(imm_q[11:0])),
    .wdata_i   (csr_new),
    .trap_i    (load_res && cls_q == cls_trap && csr_op_q == csr_ecall),
    .mret_i    (load_res && cls_q == cls_trap && csr_op_q == csr_mret),
    .trap_pc_i (pc_q),
    .rdata_o   (csr_old),
    .mepc_o    (mepc),
    .mtvec_o   (mtvec)
  );

  assign pc4      = pc_q + 64'd4;
  assign jump_sum = src1_q + imm_q;         // also the memory address.
  assign taken    = alu_res[0] ^ f3_q[0];   // odd funct3 inverts the test.

  always_comb begin
    case (csr_op_q)
      csr_rs:  csr_new = csr_old | src1_q;
      csr_rc:  csr_new = csr_old & ~src1_q;
      default: csr_new = src1_q;
    endcase
  end

  always_comb begin
    rd_data_c = alu_res;
    npc_c     = pc4;
    case (cls_q)
      cls_branch: if (taken) npc_c = pc_q + imm_q;
      cls_jump: begin
        rd_data_c = pc4;
        npc_c     = {jump_sum[xlen-1:1], 1'b0};
      end
      cls_load: rd_data_c = mem_rdata_i;
      cls_csr:  rd_data_c = csr_old;
      cls_trap: begin
        if (csr_op_q == csr_ecall) npc_c = mtvec;
        else if (csr_op_q == csr_mret) npc_c = mepc;
      end
      default: ;
    endcase
  end

  assign mem_we_o    = (cls_q == cls_store);
  assign mem_addr_o  = jump_sum;
  assign mem_wdata_o = src2_q;

  assert property (@(posedge clk) disable iff (rst)
    mem_req_o && !mem_done |=> mem_req_o && $stable(mem_addr_o) && $stable(mem_we_o));

endmodule

`default_nettype wire

// File: rv_result.sv
`timescale 1ns/100ps
`default_nettype none

module rv_result (
  input  wire                         clk,
  input  wire                         rst,
  res_if.sink                         res,
  output logic                        out_valid_o,
  input  wire                         out_ready_i,
  output logic [4:0]                  rd_o,
  output logic                        rd_we_o,
  output logic [rv_exec_pkg::xlen-1:0] rd_data_o,
  output logic [rv_exec_pkg::xlen-1:0] npc_o,
  output logic                        ebreak_o
);

  assign res.ready = !out_valid_o || out_ready_i;

  always_ff @(posedge clk) begin
    if (rst) out_valid_o <= 1'b0;
    else if (res.ready) out_valid_o <= res.valid;
  end

  always_ff @(posedge clk) begin
    if (res.ready && res.valid) begin
      rd_o      <= res.rd;
      rd_we_o   <= res.rd_we && (res.rd != 5'd0);  // x0 never written.
      rd_data_o <= res.rd_data;
      npc_o     <= res.npc;
      ebreak_o  <= res.ebreak;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(rd_data_o) && $stable(npc_o)
      && $stable(rd_o) && $stable(rd_we_o));

endmodule

`default_nettype wire

// File: rv_exec_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_exec_top (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         in_valid_i,
  output logic                        in_ready_o,
  input  wire [31:0]                  instr_i,
  input  wire [rv_exec_pkg::xlen-1:0] pc_i,
  input  wire [rv_exec_pkg::xlen-1:0] rs1_data_i,
  input  wire [rv_exec_pkg::xlen-1:0] rs2_data_i,
  output logic                        out_valid_o,
  input  wire                         out_ready_i,
  output logic [4:0]                  rd_o,
  output logic                        rd_we_o,
  output logic [rv_exec_pkg::xlen-1:0] rd_data_o,
  output logic [rv_exec_pkg::xlen-1:0] npc_o,
  output logic                        ebreak_o,
  output logic                        mem_req_o,
  output logic                        mem_we_o,
  output logic [rv_exec_pkg::xlen-1:0] mem_addr_o,
  output logic [rv_exec_pkg::xlen-1:0] mem_wdata_o,
  input  wire [rv_exec_pkg::xlen-1:0] mem_rdata_i,
  input  wire                         mem_rvalid_i,
  input  wire                         mem_wready_i
);

  dec_if dec_if_inst ();
  res_if res_if_inst ();

  rv_decode rv_decode_inst (
    .clk        (clk),
    .rst        (rst),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .instr_i    (instr_i),
    .pc_i       (pc_i),
    .rs1_data_i (rs1_data_i),
    .rs2_data_i (rs2_data_i),
    .dec        (dec_if_inst)
  );

  rv_execute rv_execute_inst (
    .clk          (clk),
    .rst          (rst),
    .dec          (dec_if_inst),
    .res          (res_if_inst),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_rdata_i  (mem_rdata_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_wready_i (mem_wready_i)
  );

  rv_result rv_result_inst (
    .clk         (clk),
    .rst         (rst),
    .res         (res_if_inst),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .rd_o        (rd_o),
    .rd_we_o     (rd_we_o),
    .rd_data_o   (rd_data_o),
    .npc_o       (npc_o),
    .ebreak_o    (ebreak_o)
  );

endmodule

`default_nettype wire

// File: tb_rv_exec.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_exec;
  import rv_exec_pkg::*;

  logic            clk = 1'b0;
  logic            rst;
  logic            in_valid_i, in_ready_o, out_valid_o, out_ready_i;
  logic [31:0]     instr_i;
  logic [xlen-1:0] pc_i, rs1_data_i, rs2_data_i, rd_data_o, npc_o;
  logic [4:0]      rd_o;
  logic            rd_we_o, ebreak_o;
  logic            mem_req_o, mem_we_o, mem_rvalid_i, mem_wready_i;
  logic [xlen-1:0] mem_addr_o, mem_wdata_o, mem_rdata_i;

  int unsigned     seed;
  int              errors, checks, delay;
  logic [63:0]     mem [16];
  logic [63:0]     last_addr, last_wdata;
  logic            last_we, answered;

  always #4 clk = ~clk;

  rv_exec_top rv_exec_top_inst (
    .clk(clk), .rst(rst),
    .in_valid_i(in_valid_i), .in_ready_o(in_ready_o), .instr_i(instr_i),
    .pc_i(pc_i), .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i),
    .out_valid_o(out_valid_o), .out_ready_i(out_ready_i), .rd_o(rd_o),
    .rd_we_o(rd_we_o), .rd_data_o(rd_data_o), .npc_o(npc_o), .ebreak_o(ebreak_o),
    .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
    .mem_wdata_o(mem_wdata_o), .mem_rdata_i(mem_rdata_i),
    .mem_rvalid_i(mem_rvalid_i), .mem_wready_i(mem_wready_i)
  );

  function logic [63:0] fill_word(input int idx);
    return 64'h0101_0101_0101_0101 * (idx + 1);
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory responder, one strobe after 1 to 4 cycles.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always begin
    @(posedge clk);
    #1;
    if (!rst && mem_req_o) begin
      delay = $urandom_range(4, 1);
      repeat (delay - 1) begin
        @(posedge clk);
        #1;
      end
      last_addr  = mem_addr_o;
      last_we    = mem_we_o;
      last_wdata = mem_wdata_o;
      answered   = 1'b1;
      if (mem_we_o) begin
        mem[mem_addr_o[6:3]] = mem_wdata_o;
        mem_wready_i = 1'b1;
      end else begin
        mem_rdata_i  = mem[mem_addr_o[6:3]];
        mem_rvalid_i = 1'b1;
      end
      @(posedge clk);
      #1;
      mem_wready_i = 1'b0;
      mem_rvalid_i = 1'b0;
    end
  end

  function logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};
  endfunction

  function logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                              input logic [4:0] rd, input logic [6:0] opc);
    return {imm, 5'd1, f3, rd, opc};
  endfunction

  function logic [31:0] enc_s(input logic [11:0] imm);
    return {imm[11:5], 5'd2, 5'd1, 3'b011, imm[4:0], 7'b0100011};
  endfunction

  function logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task expect_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  task end_test(input string name, input int e0);
    $display("%-16s done, %0d errors", name, errors - e0);
  endtask

  // called 1 ns after an edge; returns 1 ns after the accepting edge.
  task issue(input logic [31:0] instr, input logic [63:0] pc, input logic [63:0] rs1,
             input logic [63:0] rs2);
    int n;
    in_valid_i = 1'b1;
    instr_i    = instr;
    pc_i       = pc;
    rs1_data_i = rs1;
    rs2_data_i = rs2;
    n = 0;
    while (!in_ready_o && n < 50) begin
      @(posedge clk);
      #1;
      n++;
    end
    expect_true(in_ready_o, "in_ready_o stayed low for 50 cycles");
    @(posedge clk);
    #1;
  endtask

  task await_result;
    int n;
    n = 0;
    while (!out_valid_o && n < 50) begin
      @(posedge clk);
      #1;
      n++;
    end
    expect_true(out_valid_o, "no result on out_valid_o within 50 cycles");
  endtask

  task execute_one(input logic [31:0] instr, input logic [63:0] pc, input logic [63:0] rs1,
                   input logic [63:0] rs2);
    issue(instr, pc, rs1, rs2);
    in_valid_i = 1'b0;
    await_result();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task reset_and_alu;
    int          e0, sel;
    logic [63:0] a, b, pc, exp;
    logic [4:0]  rd;
    logic [31:0] instr;
    e0 = errors;
    expect_eq("out_valid_o", out_valid_o, 0);
    expect_eq("mem_req_o", mem_req_o, 0);
    expect_eq("in_ready_o", in_ready_o, 1);
    for (int i = 0; i < 20; i++) begin
      a   = {$urandom, $urandom};
      b   = {$urandom, $urandom};
      rd  = 5'($urandom_range(31, 0));
      if (i == 0) rd = 5'd0;  // x0 target.
      pc  = {32'h0, $urandom} & ~64'h3;
      sel = i % 7;
      if (sel == 4) a[63] = 1'b1;  // sign fill shows.
      case (sel)
        0: instr = enc_r(7'h00, 3'b000, rd);
        1: instr = enc_r(7'h20, 3'b000, rd);
        2: instr = enc_r(7'h00, 3'b100, rd);
        3: instr = enc_r(7'h00, 3'b001, rd);
        4: instr = enc_r(7'h20, 3'b101, rd);
        5: instr = enc_r(7'h00, 3'b011, rd);
        default: instr = {b[19:0], rd, 7'b0110111};
      endcase
      case (sel)
        0: exp = a + b;
        1: exp = a - b;
        2: exp = a ^ b;
        3: exp = a << b[5:0];
        4: exp = $signed(a) >>> b[5:0];
        5: exp = (a < b) ? 64'd1 : 64'd0;
        default: exp = {{32{b[19]}}, b[19:0], 12'h000};  // lui.
      endcase
      execute_one(instr, pc, a, b);
      expect_eq("rd_data_o", rd_data_o, exp);
      expect_eq("npc_o", npc_o, pc + 64'd4);
      expect_eq("rd_o", rd_o, rd);
      expect_eq("rd_we_o", rd_we_o, rd != 5'd0);
    end
    end_test("reset_and_alu", e0);
  endtask

  task branch_and_jump;
    int          e0;
    logic [63:0] a, b, pc, exp_npc;
    logic [2:0]  f3;
    logic        cond;
    e0 = errors;
    pc = 64'h4000;
    for (int k = 0; k < 4; k++) begin
      f3 = (k == 0) ? 3'b000 : (k == 1) ? 3'b001 : (k == 2) ? 3'b100 : 3'b111;
      for (int p = 0; p < 3; p++) begin
        a = (p == 2) ? 64'd9 : 64'hffff_ffff_ffff_fffe;
        b = (p == 0) ? 64'hffff_ffff_ffff_fffe : (p == 1) ? 64'd7 : 64'd3;
        case (f3)
          3'b000: cond = (a == b);
          3'b001: cond = (a != b);
          3'b100: cond = ($signed(a) < $signed(b));
          default: cond = (a >= b);
        endcase
        exp_npc = cond ? pc - 64'd24 : pc + 64'd4;
        execute_one(enc_b(13'h1fe8, f3), pc, a, b);
        expect_eq("npc_o", npc_o, exp_npc);
        expect_eq("rd_we_o", rd_we_o, 0);
        pc = pc + 64'd16;
      end
    end
    execute_one(enc_j(21'h00f10, 5'd1), pc, 64'h0, 64'h0);
    expect_eq("rd_data_o", rd_data_o, pc + 64'd4);
    expect_eq("npc_o", npc_o, pc + 64'hf10);
    expect_eq("rd_we_o", rd_we_o, 1);
    execute_one(enc_i(12'hff3, 3'b000, 5'd1, 7'b1100111), pc, 64'h8000_1236, 64'h0);
    expect_eq("rd_data_o", rd_data_o, pc + 64'd4);
    expect_eq("npc_o", npc_o, (64'h8000_1236 - 64'd13) & ~64'h1);  // odd sum.
    end_test("branch_and_jump", e0);
  endtask

  task load_store;
    int          e0;
    logic [63:0] data;
    e0 = errors;
    data = {$urandom, $urandom};
    answered = 1'b0;
    execute_one(enc_s(12'h028), 64'h100, 64'h1000, data);
    expect_true(answered, "sd result came out before the memory answered");
    expect_eq("mem_addr_o", last_addr, 64'h1028);
    expect_eq("mem_we_o", last_we, 1);
    expect_eq("mem_wdata_o", last_wdata, data);
    expect_eq("npc_o", npc_o, 64'h104);
    expect_eq("rd_we_o", rd_we_o, 0);
    answered = 1'b0;
    execute_one(enc_i(12'hff8, 3'b011, 5'd4, 7'b0000011), 64'h104, 64'h1030, 64'h0);
    expect_true(answered, "ld result came out before the memory answered");
    expect_eq("mem_addr_o", last_addr, 64'h1028);
    expect_eq("mem_we_o", last_we, 0);
    expect_eq("rd_data_o", rd_data_o, data);
    execute_one(enc_i(12'h008, 3'b011, 5'd5, 7'b0000011), 64'h108, 64'h1040, 64'h0);
    expect_eq("mem_addr_o", last_addr, 64'h1048);
    expect_eq("rd_data_o", rd_data_o, fill_word(9));  // untouched entry.
    end_test("load_store", e0);
  endtask

  task csr_and_trap;
    int e0;
    e0 = errors;
    execute_one(enc_i(12'h305, 3'b001, 5'd3, 7'b1110011), 64'h200, 64'h8000_0100, 64'h0);
    expect_eq("rd_data_o", rd_data_o, 64'h0);
    execute_one(enc_i(12'h300, 3'b010, 5'd3, 7'b1110011), 64'h204, 64'h88, 64'h0);
    expect_eq("rd_data_o", rd_data_o, 64'h0);
    execute_one(enc_i(12'h300, 3'b011, 5'd3, 7'b1110011), 64'h208, 64'h08, 64'h0);
    expect_eq("rd_data_o", rd_data_o, 64'h88);
    execute_one(enc_i(12'h300, 3'b010, 5'd3, 7'b1110011), 64'h20c, 64'h0, 64'h0);
    expect_eq("rd_data_o", rd_data_o, 64'h80);
    execute_one(32'h0000_0073, 64'h2000_0040, 64'h0, 64'h0);  // ecall.
    expect_eq("npc_o", npc_o, 64'h8000_0100);
    expect_eq("rd_we_o", rd_we_o, 0);
    expect_eq("ebreak_o", ebreak_o, 0);
    execute_one(enc_i(12'h341, 3'b010, 5'd3, 7'b1110011), 64'h8000_0100, 64'h0, 64'h0);
    expect_eq("rd_data_o", rd_data_o, 64'h2000_0040);
    execute_one(enc_i(12'h342, 3'b010, 5'd3, 7'b1110011), 64'h8000_0104, 64'h0, 64'h0);
    expect_eq("rd_data_o", rd_data_o, 64'd11);
    execute_one(32'h3020_0073, 64'h8000_0108, 64'h0, 64'h0);  // mret.
    expect_eq("npc_o", npc_o, 64'h2000_0040);
    execute_one(enc_i(12'h300, 3'b010, 5'd3, 7'b1110011), 64'h2000_0040, 64'h0, 64'h0);
    expect_eq("rd_data_o", rd_data_o, 64'h88);  // mie from mpie.
    execute_one(32'h0010_0073, 64'h2000_0044, 64'h0, 64'h0);  // ebreak.
    expect_eq("ebreak_o", ebreak_o, 1);
    expect_eq("npc_o", npc_o, 64'h2000_0048);
    end_test("csr_and_trap", e0);
  endtask

  task back_pressure;
    int          e0, got, n;
    logic        holding;
    logic [63:0] held_data, held_npc;
    logic [63:0] exp_data [3];
    e0 = errors;
    for (int i = 0; i < 3; i++) begin
      exp_data[i] = 64'h1111 * (i + 1) + 64'h20;
    end
    got = 0;
    n = 0;
    holding = 1'b0;
    fork
      begin
        for (int i = 0; i < 3; i++) begin
          issue(enc_r(7'h00, 3'b000, 5'(5 + i)), 64'h3000 + 4 * i, 64'h1111 * (i + 1), 64'h20);
        end
        in_valid_i = 1'b0;
      end
      begin
        while (got < 3 && n < 200) begin
          @(posedge clk);
          #1;
          n++;
          out_ready_i = ($urandom_range(2, 0) == 0);
          if (out_valid_o) begin
            if (holding) begin
              expect_eq("rd_data_o", rd_data_o, held_data);
              expect_eq("npc_o", npc_o, held_npc);
            end else begin
              held_data = rd_data_o;
              held_npc  = npc_o;
              holding   = 1'b1;
            end
            if (out_ready_i) begin
              expect_eq("rd_data_o", rd_data_o, exp_data[got]);
              expect_eq("npc_o", npc_o, 64'h3004 + 4 * got);
              expect_eq("rd_o", rd_o, 5 + got);
              got++;
              holding = 1'b0;
            end
          end
        end
        expect_true(got == 3, "back-pressure results missing after 200 cycles");
      end
    join
    out_ready_i = 1'b1;
    repeat (5) begin
      @(posedge clk);
      #1;
      expect_eq("out_valid_o", out_valid_o, 0);  // no duplicate.
    end
    end_test("back_pressure", e0);
  endtask

  initial begin
    seed = 32'h6dac;
    void'($urandom(seed));
    errors = 0;
    checks = 0;
    rst = 1'b1;
    in_valid_i = 1'b0;
    instr_i = 32'h0;
    pc_i = '0;
    rs1_data_i = '0;
    rs2_data_i = '0;
    out_ready_i = 1'b1;
    mem_rdata_i = '0;
    mem_rvalid_i = 1'b0;
    mem_wready_i = 1'b0;
    for (int i = 0; i < 16; i++) begin
      mem[i] = fill_word(i);
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_and_alu();
    branch_and_jump();
    load_store();
    csr_and_trap();
    back_pressure();
    $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
rv_exec_pkg.sv
rv_stage_if.sv
rv_alu.sv
rv_csr_file.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_exec_top.sv
tb_rv_exec.sv

// File: Bender.yml
package:
  name: rv_exec

sources:
  - rv_exec_pkg.sv
  - rv_stage_if.sv
  - rv_alu.sv
  - rv_csr_file.sv
  - rv_decode.sv
  - rv_execute.sv
  - rv_result.sv
  - rv_exec_top.sv
  - target: test
    files:
      - tb_rv_exec.sv
